/* flist.f */
+incdir+design
design/isa_pkg.sv
design/ctrl_pkg.sv
design/ir_controller.sv
design/reg_file.sv
design/exec_unit.sv
design/inst_memory.sv
design/data_memory.sv
design/cpu_top.sv
verif/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module cpu_tb -Mdir obj_dir

sim_out=$(./obj_dir/Vcpu_tb 2>&1) || { echo "$sim_out"; exit 1; }
echo "$sim_out"

if grep -q "PASS: all tests" <<< "$sim_out"; then
  exit 0
else
  exit 1
fi

/* verif/cpu_tb.sv */
// testbench for the multi-cycle core that checks writebacks, stores and the retired count
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb import isa_pkg::*; ();

  logic              clock;
  logic              reset;
  logic              load;
  im_addr_t          load_addr;
  word_t             load_data;
  logic              wb_valid;
  reg_addr_t         wb_addr;
  word_t             wb_data;
  logic              st_valid;
  dm_addr_t          st_addr;
  word_t             st_data;
  logic [`CNT_W-1:0] ins_cnt;

  word_t     prog [$];
  reg_addr_t exp_wb_addr [$];
  word_t     exp_wb_data [$];
  dm_addr_t  exp_st_addr [$];
  word_t     exp_st_data [$];
  int        exp_count = 0;
  int        cycle_cnt = 0;
  int        cycle_limit = 0;
  int        err_cnt = 0;
  int        wb_seen = 0;
  int        first_wb_cycle = 0;

  cpu_top u_cpu_top (
    .clock     (clock),
    .reset     (reset),
    .load      (load),
    .load_addr (load_addr),
    .load_data (load_data),
    .wb_valid  (wb_valid),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .st_valid  (st_valid),
    .st_addr   (st_addr),
    .st_data   (st_data),
    .ins_cnt   (ins_cnt)
  );

  always #20 clock = ~clock;

  function automatic word_t basic_word(logic [4:0] sub, reg_addr_t rt, reg_addr_t ra,
                                       logic [4:0] rb);
    return {1'b0, TYPE_BASIC, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic word_t imm_word(logic [5:0] op, reg_addr_t rt, reg_addr_t ra,
                                     logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic word_t movi_word(reg_addr_t rt, logic [19:0] imm);
    return {1'b0, MOVI, rt, imm};
  endfunction

  function automatic word_t ls_word(logic [7:0] sub, reg_addr_t rt, reg_addr_t ra,
                                    reg_addr_t rb, logic [1:0] sv);
    return {1'b0, TYPE_LS, rt, ra, rb, sv, sub};
  endfunction

  // general registers are r1 to r12 while r13 and r14 hold the memory base and index
  function automatic reg_addr_t pick_reg();
    return reg_addr_t'($urandom_range(12, 1));
  endfunction

  // instruction set model over the whole program image
  function automatic void run_reference();
    word_t      regs [32];
    word_t      mem [1 << `DM_AW];
    word_t      w;
    word_t      a;
    word_t      res;
    logic [5:0] op;
    reg_addr_t  rt;
    reg_addr_t  ra;
    reg_addr_t  rb;
    logic [4:0] sh;
    dm_addr_t   addr;
    logic       is_load;
    logic       is_store;
    foreach (prog[i]) begin
      w   = prog[i];
      op  = w[30:25];
      rt  = w[24:20];
      ra  = w[19:15];
      rb  = w[14:10];
      sh  = w[14:10];
      a   = regs[ra];
      res = '0;
      addr = '0;
      if (op == TYPE_BASIC && w[4:0] == SRLI && rt == 0 && ra == 0 && sh == 0) begin
        continue;
      end
      case (op)
        MOVI: res = {{12{w[19]}}, w[19:0]};
        ADDI: res = a + {{17{w[14]}}, w[14:0]};
        ORI:  res = a | {17'd0, w[14:0]};
        XORI: res = a ^ {17'd0, w[14:0]};
        LWI, SWI: addr = dm_addr_t'(a + {17'd0, w[14:0]});
        TYPE_LS:  addr = dm_addr_t'(a + (regs[rb] << w[9:8]));
        TYPE_BASIC: begin
          case (w[4:0])
            ADD:  res = a + regs[rb];
            SUB:  res = a - regs[rb];
            AND:  res = a & regs[rb];
            OR:   res = a | regs[rb];
            XOR:  res = a ^ regs[rb];
            SRLI: res = a >> sh;
            SLLI: res = a << sh;
            default: res = (a >> sh) | (a << (6'd32 - sh));
          endcase
        end
        default: res = '0;
      endcase
      is_load  = (op == LWI) || (op == TYPE_LS && w[7:0] == LW);
      is_store = (op == SWI) || (op == TYPE_LS && w[7:0] == SW);
      if (is_load) begin
        res = mem[addr];
      end
      if (is_store) begin
        mem[addr] = regs[rt];
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(regs[rt]);
      end else begin
        regs[rt] = res;
        exp_wb_addr.push_back(rt);
        exp_wb_data.push_back(res);
      end
      exp_count++;
    end
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  initial begin
    logic [4:0]  subs [8];
    logic [14:0] off;
    logic [1:0]  sv;
    int          k;
    int          reset_cycles;
    clock     = 1'b0;
    reset     = 1'b1;
    load      = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(32'hbba6));
    subs = '{ADD, SUB, AND, OR, XOR, SRLI, SLLI, ROTRI};

    for (int r = 1; r <= 12; r++) begin
      prog.push_back(movi_word(reg_addr_t'(r), 20'($urandom())));
    end
    prog.push_back(movi_word(5'd13, 20'($urandom_range(255, 0))));
    prog.push_back(movi_word(5'd14, 20'($urandom_range(15, 1))));
    prog.push_back(movi_word(pick_reg(), 20'($urandom()) | 20'h80000));
    // negative and positive addi offsets
    prog.push_back(imm_word(ADDI, pick_reg(), pick_reg(), 15'($urandom()) | 15'h4000));
    prog.push_back(imm_word(ADDI, pick_reg(), pick_reg(), 15'($urandom()) & 15'h3fff));
    // top immediate bit set so zero extension differs from sign extension
    prog.push_back(imm_word(ORI, pick_reg(), pick_reg(), 15'($urandom()) | 15'h4000));
    prog.push_back(imm_word(XORI, pick_reg(), pick_reg(), 15'($urandom()) | 15'h4000));
    for (int i = 0; i < 8; i++) begin
      prog.push_back(basic_word(subs[i], pick_reg(), pick_reg(),
                                (i < 5) ? pick_reg() : 5'($urandom())));
    end
    prog.push_back(basic_word(SRLI, '0, '0, '0));

    off = 15'($urandom_range(255, 1));
    sv  = 2'($urandom_range(3, 1));
    prog.push_back(imm_word(SWI, pick_reg(), 5'd13, off));
    prog.push_back(imm_word(LWI, 5'd15, 5'd13, off));
    prog.push_back(ls_word(SW, pick_reg(), 5'd13, 5'd14, sv));
    prog.push_back(ls_word(LW, 5'd16, 5'd13, 5'd14, sv));

    for (int i = 0; i < 12; i++) begin
      k = $urandom_range(7, 0);
      prog.push_back(basic_word(subs[k], pick_reg(), pick_reg(),
                                (k < 5) ? pick_reg() : 5'($urandom())));
    end
    // padding after the last instruction
    repeat (4) prog.push_back(basic_word(SRLI, '0, '0, '0));

    run_reference();
    reset_cycles = prog.size() + 11;
    cycle_limit  = reset_cycles + 8 * prog.size() + 100;

    // held through the program load and ten cycles after
    foreach (prog[i]) begin
      @(posedge clock);
      load      <= 1'b1;
      load_addr <= im_addr_t'(i);
      load_data <= prog[i];
    end
    @(posedge clock);
    load <= 1'b0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    while (exp_wb_addr.size() != 0 || exp_st_addr.size() != 0 || ins_cnt != exp_count) begin
      @(negedge clock);
    end
    // two padding nops must not retire
    repeat (16) @(negedge clock);
    check_value("ins_cnt", ins_cnt, exp_count);

    if (err_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "checks failed");
    end
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      abort_run($sformatf("timeout, the program did not finish in %0d cycles", cycle_limit));
    end
  end

  // compare mid cycle where the trace port is settled
  always @(negedge clock) begin
    if (!reset && wb_valid === 1'b1) begin
      if (exp_wb_addr.size() == 0) begin
        abort_run("a register writeback appeared when none was expected");
      end else begin
        check_value("wb_addr", wb_addr, exp_wb_addr.pop_front());
        check_value("wb_data", wb_data, exp_wb_data.pop_front());
      end
      if (wb_seen == 1) begin
        check_value("wb_spacing", cycle_cnt - first_wb_cycle, 8);
      end
      if (wb_seen == 0) begin
        first_wb_cycle = cycle_cnt;
      end
      wb_seen++;
    end
    if (!reset && st_valid === 1'b1) begin
      if (exp_st_addr.size() == 0) begin
        abort_run("a data memory write appeared when none was expected");
      end else begin
        check_value("st_addr", st_addr, exp_st_addr.pop_front());
        check_value("st_data", st_data, exp_st_data.pop_front());
      end
    end
  end

endmodule

/* design/cpu_top.sv */
// multi-cycle core top, controller with its datapath blocks and the trace port
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top import isa_pkg::*, ctrl_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              load,
  input  im_addr_t          load_addr,
  input  word_t             load_data,
  output logic              wb_valid,
  output reg_addr_t         wb_addr,
  output word_t             wb_data,
  output logic              st_valid,
  output dm_addr_t          st_addr,
  output word_t             st_data,
  output logic [`CNT_W-1:0] ins_cnt
);

  word_t    instr;
  im_addr_t im_address;
  decoded_t dec;
  ctrl_t    ctrl;
  word_t    rdata_a;
  word_t    rdata_b;
  word_t    alu_result;
  word_t    dm_rdata;
  dm_addr_t dm_addr;

  // word address from the low alu bits
  assign dm_addr = alu_result[`DM_AW-1:0];

  assign st_valid = ctrl.dm_write;
  assign st_addr  = dm_addr;
  assign st_data  = rdata_b;

  ir_controller u_ir_controller (
    .clock      (clock),
    .reset      (reset),
    .instr      (instr),
    .im_address (im_address),
    .dec        (dec),
    .ctrl       (ctrl),
    .ins_cnt    (ins_cnt)
  );

  inst_memory u_inst_memory (
    .clock      (clock),
    .reset      (reset),
    .load       (load),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .im_fetch   (ctrl.im_fetch),
    .im_address (im_address),
    .instr      (instr)
  );

  reg_file u_reg_file (
    .clock      (clock),
    .ctrl       (ctrl),
    .dec        (dec),
    .alu_result (alu_result),
    .dm_rdata   (dm_rdata),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .wb_valid   (wb_valid),
    .wb_addr    (wb_addr),
    .wb_data    (wb_data)
  );

  exec_unit u_exec_unit (
    .clock      (clock),
    .reset      (reset),
    .ctrl       (ctrl),
    .dec        (dec),
    .rdata_a    (rdata_a),
    .rdata_b    (rdata_b),
    .alu_result (alu_result)
  );

  data_memory u_data_memory (
    .clock    (clock),
    .dm_fetch (ctrl.dm_fetch),
    .dm_write (ctrl.dm_write),
    .dm_addr  (dm_addr),
    .wdata    (rdata_b),
    .rdata    (dm_rdata)
  );

endmodule

/* design/data_memory.sv */
// word addressed data memory with registered read and strobed write
`timescale 1ns/1ps
`include "cpu_config.svh"

module data_memory import isa_pkg::*; (
  input  logic     clock,
  input  logic     dm_fetch,
  input  logic     dm_write,
  input  dm_addr_t dm_addr,
  input  word_t    wdata,
  output word_t    rdata
);

  word_t mem [1 << `DM_AW];

  always_ff @(posedge clock) begin
    if (dm_write) begin
      mem[dm_addr] <= wdata;
    end
  end

  always_ff @(posedge clock) begin
    if (dm_fetch) begin
      rdata <= mem[dm_addr];
    end
  end

endmodule

/* design/inst_memory.sv */
// instruction memory loaded while in reset, with a registered fetch port
`timescale 1ns/1ps
`include "cpu_config.svh"

module inst_memory import isa_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     load,
  input  im_addr_t load_addr,
  input  word_t    load_data,
  input  logic     im_fetch,
  input  im_addr_t im_address,
  output word_t    instr
);

  word_t mem [1 << `IM_AW];

  always_ff @(posedge clock) begin
    if (reset && load) begin
      mem[load_addr] <= load_data;
    end
  end

  always_ff @(posedge clock) begin
    if (im_fetch) begin
      instr <= mem[im_address];
    end
  end

  // program image only changes while the core is held
  assert property (@(posedge clock) load |-> reset);

endmodule

/* design/exec_unit.sv */
// execute unit that extends the immediate, selects operand b and runs the alu
`timescale 1ns/1ps
`include "cpu_config.svh"

module exec_unit import isa_pkg::*, ctrl_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  ctrl_t    ctrl,
  input  decoded_t dec,
  input  word_t    rdata_a,
  input  word_t    rdata_b,
  output word_t    alu_result
);

  word_t                       imm;
  word_t                       opb;
  word_t                       result;
  logic [$clog2(`DATA_W)-1:0]  shamt;
  logic [2*`DATA_W-1:0]        rot;

  always_comb begin
    case (ctrl.imm_sel)
      imm15_se: imm = {{(`DATA_W-15){dec.imm15[14]}}, dec.imm15};
      imm15_ze: imm = {{(`DATA_W-15){1'b0}}, dec.imm15};
      imm20_se: imm = {{(`DATA_W-20){dec.imm20[19]}}, dec.imm20};
      default:  imm = {{(`DATA_W-5){1'b0}}, dec.imm5};
    endcase
  end

  // lw and sw scale the index register by sv
  assign opb   = ctrl.use_imm ? imm : (rdata_b << ctrl.sv);
  assign shamt = opb[$clog2(`DATA_W)-1:0];
  assign rot   = {rdata_a, rdata_a} >> shamt;

  always_comb begin
    case (ctrl.alu_op)
      alu_sub:  result = rdata_a - opb;
      alu_and:  result = rdata_a & opb;
      alu_or:   result = rdata_a | opb;
      alu_xor:  result = rdata_a ^ opb;
      alu_srl:  result = rdata_a >> shamt;
      alu_sll:  result = rdata_a << shamt;
      alu_rotr: result = rot[`DATA_W-1:0];
      alu_mov:  result = opb;
      default:  result = rdata_a + opb;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result <= '0;
    end else if (ctrl.alu_execute) begin
      alu_result <= result;
    end
  end

endmodule

/* design/reg_file.sv */
// register file with two registered read ports and one strobed write port
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file import isa_pkg::*, ctrl_pkg::*; (
  input  logic      clock,
  input  ctrl_t     ctrl,
  input  decoded_t  dec,
  input  word_t     alu_result,
  input  word_t     dm_rdata,
  output word_t     rdata_a,
  output word_t     rdata_b,
  output logic      wb_valid,
  output reg_addr_t wb_addr,
  output word_t     wb_data
);

  word_t     regs [1 << `REG_AW];
  logic      past_exe;
  logic      read_rt;
  reg_addr_t addr_b;

  // set once the address is computed, so a second read is the store data read
  always_ff @(posedge clock) begin
    if (ctrl.im_fetch) begin
      past_exe <= 1'b0;
    end else if (ctrl.alu_execute) begin
      past_exe <= 1'b1;
    end
  end

  // swi reads rt at once, sw reads it on its second pass
  assign read_rt = (dec.opcode == SWI) ||
                   ((dec.opcode == TYPE_LS) && (dec.sub8 == SW) && past_exe);
  assign addr_b  = read_rt ? dec.rt : dec.rb;

  assign wb_valid = ctrl.reg_write;
  assign wb_addr  = dec.rt;
  assign wb_data  = ctrl.wb_from_dm ? dm_rdata : alu_result;

  always_ff @(posedge clock) begin
    if (ctrl.reg_read) begin
      rdata_a <= regs[dec.ra];
      rdata_b <= regs[addr_b];
    end
    if (wb_valid) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // once the controller is out of its unknown power-up state
  assert property (@(posedge clock) !$isunknown(ctrl.im_fetch) |-> !$isunknown(wb_valid));

endmodule

/* design/ir_controller.sv */
// instruction controller that fetches, decodes and steps each instruction through eight states
`timescale 1ns/1ps
`include "cpu_config.svh"

module ir_controller import isa_pkg::*, ctrl_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  word_t             instr,
  output im_addr_t          im_address,
  output decoded_t          dec,
  output ctrl_t             ctrl,
  output logic [`CNT_W-1:0] ins_cnt
);

  ctrl_state_e state;
  ctrl_state_e state_next;
  im_addr_t    pc;
  word_t       ir;
  word_t       cur_word;
  logic        is_ls;
  logic        is_load;
  logic        is_sw;
  logic        is_store;
  logic        is_nop;

  assign im_address = pc;

  // during fetch the word is still only in the memory output register
  assign cur_word = (state == fetch) ? instr : ir;

  always_comb begin
    dec.opcode = opcode_e'(cur_word[30:25]);
    dec.sub5   = basic_op_e'(cur_word[4:0]);
    dec.sub8   = ls_op_e'(cur_word[7:0]);
    dec.sv     = cur_word[9:8];
    dec.imm5   = cur_word[14:10];
    dec.imm15  = cur_word[14:0];
    dec.imm20  = cur_word[19:0];
    dec.rt     = cur_word[24:20];
    dec.ra     = cur_word[19:15];
    dec.rb     = cur_word[14:10];
  end

  assign is_ls    = (dec.opcode == TYPE_LS);
  assign is_sw    = is_ls && (dec.sub8 == SW);
  assign is_load  = (is_ls && (dec.sub8 == LW)) || (dec.opcode == LWI);
  assign is_store = is_sw || (dec.opcode == SWI);
  assign is_nop   = (dec.opcode == TYPE_BASIC) && (dec.sub5 == SRLI) &&
                    (dec.rt == '0) && (dec.ra == '0) && (dec.imm5 == '0);

  // every instruction walks all eight states in a fixed order
  always_comb begin
    case (state)
      stop:     state_next = fetch;
      fetch:    state_next = exe;
      exe:      state_next = lw_fetch;
      lw_fetch: state_next = lw_write;
      lw_write: state_next = write;
      write:    state_next = sw_fetch;
      sw_fetch: state_next = sw_write;
      default:  state_next = stop;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= stop;
      pc      <= '0;
      ins_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == sw_write) begin
        pc <= pc + 1'b1;
        if (!is_nop) begin
          ins_cnt <= ins_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == fetch) begin
      ir <= instr;
    end
  end

  always_comb begin
    ctrl             = '0;
    ctrl.im_fetch    = (state == stop);
    ctrl.reg_read    = (state == fetch) || ((state == sw_fetch) && is_sw);
    ctrl.alu_execute = (state == exe);
    ctrl.dm_fetch    = (state == lw_fetch) && is_load;
    ctrl.reg_write   = (state == write) && !is_nop && !is_store;
    ctrl.dm_write    = (state == sw_write) && is_store;
    ctrl.wb_from_dm  = is_load;
    // register offset shift only for lw and sw
    ctrl.sv          = is_ls ? dec.sv : 2'b00;
    ctrl.imm_sel     = imm5_ze;
    ctrl.use_imm     = 1'b0;
    ctrl.alu_op      = alu_add;
    case (dec.opcode)
      TYPE_BASIC: begin
        case (dec.sub5)
          SUB:   ctrl.alu_op = alu_sub;
          AND:   ctrl.alu_op = alu_and;
          OR:    ctrl.alu_op = alu_or;
          XOR:   ctrl.alu_op = alu_xor;
          SRLI:  ctrl.alu_op = alu_srl;
          SLLI:  ctrl.alu_op = alu_sll;
          ROTRI: ctrl.alu_op = alu_rotr;
          default: ctrl.alu_op = alu_add;
        endcase
        ctrl.use_imm = (dec.sub5 == SRLI) || (dec.sub5 == SLLI) || (dec.sub5 == ROTRI);
      end
      ADDI: begin
        ctrl.imm_sel = imm15_se;
        ctrl.use_imm = 1'b1;
      end
      ORI: begin
        ctrl.imm_sel = imm15_ze;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = alu_or;
      end
      XORI: begin
        ctrl.imm_sel = imm15_ze;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = alu_xor;
      end
      MOVI: begin
        ctrl.imm_sel = imm20_se;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = alu_mov;
      end
      LWI, SWI: begin
        ctrl.imm_sel = imm15_ze;
        ctrl.use_imm = 1'b1;
      end
      default: ctrl.use_imm = 1'b0;
    endcase
  end

  // an instruction that writes a register never stores
  assert property (@(posedge clock) disable iff (reset)
    ctrl.reg_write |-> !ctrl.dm_write ##2 !ctrl.dm_write);

  // a store lands five steps after execute and the next fetch follows
  assert property (@(posedge clock) disable iff (reset)
    ctrl.dm_write |-> $past(ctrl.alu_execute, 5) ##1 ctrl.im_fetch);

endmodule

/* design/ctrl_pkg.sv */
// control package with the sequencer states, datapath selections and strobe bundle
package ctrl_pkg;

  typedef enum logic [2:0] {
    stop     = 3'b000,
    fetch    = 3'b001,
    exe      = 3'b010,
    write    = 3'b011,
    lw_fetch = 3'b100,
    lw_write = 3'b101,
    sw_fetch = 3'b110,
    sw_write = 3'b111
  } ctrl_state_e;

  // immediate extension choice
  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_srl,
    alu_sll,
    alu_rotr,
    alu_mov
  } alu_op_e;

  typedef struct packed {
    logic       im_fetch;
    logic       reg_read;
    logic       alu_execute;
    logic       dm_fetch;
    logic       dm_write;
    logic       reg_write;
    imm_sel_e   imm_sel;
    logic       use_imm;
    alu_op_e    alu_op;
    logic       wb_from_dm;
    logic [1:0] sv;
  } ctrl_t;

endpackage

/* design/isa_pkg.sv */
// instruction set package with word types, opcode encodings and the decoded fields
`include "cpu_config.svh"

package isa_pkg;

  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [`IM_AW-1:0]  im_addr_t;
  typedef logic [`DM_AW-1:0]  dm_addr_t;

  // major opcode, bits 30:25
  typedef enum logic [5:0] {
    TYPE_BASIC = 6'b100000,
    ADDI       = 6'b101000,
    ORI        = 6'b101100,
    XORI       = 6'b101011,
    LWI        = 6'b000010,
    SWI        = 6'b001010,
    MOVI       = 6'b100010,
    TYPE_LS    = 6'b011100
  } opcode_e;

  // basic type sub-opcode, nop is srli r0, r0, 0
  typedef enum logic [4:0] {
    ADD   = 5'b00000,
    SUB   = 5'b00001,
    AND   = 5'b00010,
    XOR   = 5'b00011,
    OR    = 5'b00100,
    SLLI  = 5'b01000,
    SRLI  = 5'b01001,
    ROTRI = 5'b01011
  } basic_op_e;

  typedef enum logic [7:0] {
    LW = 8'b00000010,
    SW = 8'b00001010
  } ls_op_e;

  typedef struct packed {
    opcode_e   opcode;
    basic_op_e sub5;
    ls_op_e    sub8;
    logic [1:0]  sv;
    logic [4:0]  imm5;
    logic [14:0] imm15;
    logic [19:0] imm20;
    reg_addr_t rt;
    reg_addr_t ra;
    reg_addr_t rb;
  } decoded_t;

endpackage

/* design/cpu_config.svh */
// core configuration for the datapath, register file, memory and counter widths
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and instruction word
`define DATA_W 32

// register index, 32 registers
`define REG_AW 5

// memory word addresses
`define IM_AW 10
`define DM_AW 10

// retired instruction counter
`define CNT_W 64

`endif
